// File: ball/ball_mover.sv
`timescale 1ns/10ps
`default_nettype none

module ball_mover #(
    parameter int ball_period = pong_pkg::def_ball_period       // Cycles per step
) (
    input  wire logic                         clk_0,
    input  wire logic                         rst,            // Async, active low
    input  wire logic                         ball_live,      // Low holds at centre
    input  wire logic [pong_pkg::coord_w-1:0] pdl1_y,         // Left paddle top edge
    input  wire logic [pong_pkg::coord_w-1:0] pdl2_y,         // Right paddle top edge
    output logic [pong_pkg::coord_w-1:0]      ball_x,         // Top left corner
    output logic [pong_pkg::coord_w-1:0]      ball_y,
    output logic                              miss_left,      // One cycle strobe
    output logic                              miss_right      // One cycle strobe
);

    logic [pong_pkg::count_w-1:0] rate_cnt;     // Cycles since last step
    logic                         dir_x;        // 1 right, 0 left
    logic                         dir_y;        // 1 down, 0 up
    logic                         step;         // Step due this cycle
    logic                         miss_pending; // Waiting for the controller to react
    logic                         at_right;     // Past the right paddle
    logic                         at_left;      // Past the left paddle
    logic                         at_bottom;
    logic                         at_top;
    logic                         pdl1_rows;    // Vertical overlap with left paddle
    logic                         pdl2_rows;    // Vertical overlap with right paddle
    logic                         hit_pdl1;
    logic                         hit_pdl2;

    assign step         = (rate_cnt == ball_period - 1);
    assign miss_pending = miss_left || miss_right;

    assign at_right  = ball_x >= pong_pkg::h_video - pong_pkg::ball_size - 1;
    assign at_left   = (ball_x == '0);
    assign at_bottom = ball_y >= pong_pkg::v_video - pong_pkg::ball_size - 1;
    assign at_top    = (ball_y == '0);

    assign pdl1_rows = (ball_y <= pdl1_y + pong_pkg::pdl_height) &&
                       (ball_y + pong_pkg::ball_size >= pdl1_y);
    assign pdl2_rows = (ball_y <= pdl2_y + pong_pkg::pdl_height) &&
                       (ball_y + pong_pkg::ball_size >= pdl2_y);

    // Only the inner faces count
    assign hit_pdl2 = (ball_x + pong_pkg::ball_size >= pong_pkg::pdl2_x) && pdl2_rows;
    assign hit_pdl1 = (ball_x <= pong_pkg::pdl1_x + pong_pkg::pdl_width) && pdl1_rows;

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            rate_cnt   <= '0;
            dir_x      <= 1'b0;
            dir_y      <= 1'b0;
            ball_x     <= pong_pkg::ball_start_x;
            ball_y     <= pong_pkg::ball_start_y;
            miss_left  <= 1'b0;
            miss_right <= 1'b0;
        end else begin
            miss_left  <= 1'b0;                     // Strobes last one cycle
            miss_right <= 1'b0;
            if (!ball_live) begin
                rate_cnt <= '0;
                dir_x    <= 1'b0;                   // Serve goes left and up
                dir_y    <= 1'b0;
                ball_x   <= pong_pkg::ball_start_x;
                ball_y   <= pong_pkg::ball_start_y;
            end else if (miss_pending) begin
                rate_cnt <= '0;                     // Hold still until play stops
            end else if (!step) begin
                rate_cnt <= rate_cnt + 1'b1;
            end else begin
                rate_cnt <= '0;
                if (at_right) begin
                    miss_right <= 1'b1;
                end else if (at_left) begin
                    miss_left <= 1'b1;
                end else if (at_bottom) begin
                    dir_y  <= 1'b0;                 // Bounce off bottom wall
                    ball_y <= ball_y - 1'b1;
                end else if (at_top) begin
                    dir_y  <= 1'b1;                 // Bounce off top wall
                    ball_y <= ball_y + 1'b1;
                end else if (hit_pdl2) begin
                    dir_x  <= 1'b0;                 // Back towards player 1
                    ball_x <= ball_x - 1'b1;
                end else if (hit_pdl1) begin
                    dir_x  <= 1'b1;                 // Back towards player 2
                    ball_x <= ball_x + 1'b1;
                end else begin
                    ball_x <= dir_x ? ball_x + 1'b1 : ball_x - 1'b1;
                    ball_y <= dir_y ? ball_y + 1'b1 : ball_y - 1'b1;
                end
            end
        end
    end

    a_one_miss: assert property (
        @(posedge clk_0) disable iff (!rst)
        !(miss_left && miss_right)
    );

    a_ball_above_floor: assert property (
        @(posedge clk_0) disable iff (!rst)
        ball_y <= pong_pkg::v_video - pong_pkg::ball_size - 1
    );

endmodule

`default_nettype wire

// File: common/pong_pkg.sv
`default_nettype none

package pong_pkg;

    localparam int coord_w = 10;                            // Screen coordinate width

    localparam logic [coord_w-1:0] h_video = 10'd640;       // Active pixels per line
    localparam logic [coord_w-1:0] v_video = 10'd480;       // Active lines per frame

    localparam int ball_size  = 16;                         // Ball is a square
    localparam int pdl_width  = 12;                         // Paddle thickness
    localparam int pdl_height = 96;                         // Paddle length

    localparam logic [coord_w-1:0] pdl1_x = 10'd24;         // Left paddle, left edge
    localparam logic [coord_w-1:0] pdl2_x = 10'd603;        // Right paddle, left edge
    localparam logic [coord_w-1:0] pdl_start_y = 10'd191;   // Both paddles centred

    localparam logic [coord_w-1:0] ball_start_x = 10'd320;  // Screen centre
    localparam logic [coord_w-1:0] ball_start_y = 10'd240;

    localparam int score_w   = 4;                           // Holds 0 to 15
    localparam int max_score = 11;                          // First to this wins

    localparam int clk_hz            = 25_175_000;          // Pixel clock
    localparam int def_ball_period   = clk_hz / 200;        // 200 px/s
    localparam int def_paddle_period = clk_hz / 400;        // 400 px/s
    localparam int def_serve_delay   = 2 * clk_hz;          // 2 s pause after a point
    localparam int def_safe_start    = 2_500_000;           // About 0.1 s
    localparam int count_w           = 27;                  // Covers the serve delay

    // Controller state codes
    localparam logic [1:0] st_startup = 2'd0;
    localparam logic [1:0] st_serve   = 2'd1;
    localparam logic [1:0] st_play    = 2'd2;
    localparam logic [1:0] st_over    = 2'd3;

endpackage

`default_nettype wire

// File: logic/button_sync.sv
`timescale 1ns/10ps
`default_nettype none

module button_sync (
    input  wire logic clk_0,
    input  wire logic rst,              // Async, active low

    input  wire logic up_p1_raw,        // Straight from the pins, active low
    input  wire logic down_p1_raw,
    input  wire logic up_p2_raw,
    input  wire logic down_p2_raw,

    output logic      up_p1,            // Second stage, active low
    output logic      down_p1,
    output logic      up_p2,
    output logic      down_p2,
    output logic      any_press         // High while any button is held
);

    logic [3:0] meta;                   // First stage, may go metastable
    logic [3:0] sync;                   // Second stage, safe to use

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            meta <= 4'hf;               // All released
            sync <= 4'hf;
        end else begin
            meta <= {down_p2_raw, up_p2_raw, down_p1_raw, up_p1_raw};
            sync <= meta;
        end
    end

    assign up_p1     = sync[0];
    assign down_p1   = sync[1];
    assign up_p2     = sync[2];
    assign down_p2   = sync[3];
    assign any_press = ~&sync;          // A single low bit is a press

endmodule

`default_nettype wire

// File: logic/game_state_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module game_state_ctrl #(
    parameter int serve_delay = pong_pkg::def_serve_delay,  // Cycles of serve pause
    parameter int safe_start  = pong_pkg::def_safe_start    // Cycles with buttons ignored
) (
    input  wire logic                         clk_0,
    input  wire logic                         rst,            // Async, active low

    input  wire logic                         any_press,      // Synchronized, active high
    input  wire logic                         miss_left,      // Point to player 2
    input  wire logic                         miss_right,     // Point to player 1

    output logic                              ball_live,      // Ball may move
    output logic                              paddles_live,   // Paddles may move
    output logic                              ball_shown,
    output logic                              game_startup,
    output logic                              game_over,
    output logic [pong_pkg::score_w-1:0]      score_p1,
    output logic [pong_pkg::score_w-1:0]      score_p2
);

    logic [1:0]                   state;        // One of the pong_pkg::st_* codes
    logic [pong_pkg::count_w-1:0] wait_cnt;     // Shared by safety and serve waits

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            state    <= pong_pkg::st_startup;
            wait_cnt <= '0;
            score_p1 <= '0;
            score_p2 <= '0;
        end else begin
            case (state)
                pong_pkg::st_startup: begin
                    if (wait_cnt < safe_start) begin
                        wait_cnt <= wait_cnt + 1'b1;        // Buttons ignored for now
                    end else if (any_press) begin
                        state    <= pong_pkg::st_serve;
                        wait_cnt <= '0;
                    end
                end

                pong_pkg::st_serve: begin
                    if (wait_cnt >= serve_delay - 1) begin
                        state    <= pong_pkg::st_play;      // Ball appears and moves now
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end

                pong_pkg::st_play: begin
                    if (miss_right) begin                   // Player 1 scores
                        if (score_p1 == pong_pkg::max_score - 1) begin
                            state    <= pong_pkg::st_over;
                            score_p1 <= '0;
                            score_p2 <= '0;
                        end else begin
                            state    <= pong_pkg::st_serve;
                            score_p1 <= score_p1 + 1'b1;
                        end
                    end else if (miss_left) begin           // Player 2 scores
                        if (score_p2 == pong_pkg::max_score - 1) begin
                            state    <= pong_pkg::st_over;
                            score_p1 <= '0;
                            score_p2 <= '0;
                        end else begin
                            state    <= pong_pkg::st_serve;
                            score_p2 <= score_p2 + 1'b1;
                        end
                    end
                end

                default: begin                              // Game over
                    if (any_press) begin
                        state <= pong_pkg::st_serve;        // Scores already clear
                    end
                end
            endcase
        end
    end

    // Output decode
    assign ball_live    = (state == pong_pkg::st_play);
    assign ball_shown   = (state == pong_pkg::st_play);
    assign paddles_live = (state == pong_pkg::st_serve) || (state == pong_pkg::st_play);
    assign game_startup = (state == pong_pkg::st_startup);
    assign game_over    = (state == pong_pkg::st_over);

    a_screens_exclusive: assert property (
        @(posedge clk_0) disable iff (!rst)
        !(game_startup && game_over)
    );

    // The ball only reports misses while the game is in play
    a_miss_in_play: assert property (
        @(posedge clk_0) disable iff (!rst)
        (miss_left || miss_right) |-> (state == pong_pkg::st_play)
    );

endmodule

`default_nettype wire

// File: logic/pong_top.sv
`timescale 1ns/10ps
`default_nettype none

module pong_top #(
    parameter int ball_period   = pong_pkg::def_ball_period,    // Cycles per ball step
    parameter int paddle_period = pong_pkg::def_paddle_period,  // Cycles per paddle step
    parameter int serve_delay   = pong_pkg::def_serve_delay,    // Pause before each serve
    parameter int safe_start    = pong_pkg::def_safe_start      // Buttons ignored this long
) (
    input  wire logic                         clk_0,          // Pixel clock
    input  wire logic                         rst,            // Async, active low

    input  wire logic                         up_p1,          // Raw buttons, active low
    input  wire logic                         down_p1,
    input  wire logic                         up_p2,
    input  wire logic                         down_p2,

    output logic [pong_pkg::coord_w-1:0]      ball_x,         // Sprite top left corners
    output logic [pong_pkg::coord_w-1:0]      ball_y,
    output logic [pong_pkg::coord_w-1:0]      pdl1_y,
    output logic [pong_pkg::coord_w-1:0]      pdl2_y,

    output logic                              ball_shown,     // Draw the ball
    output logic                              game_startup,   // Title screen
    output logic                              game_over,      // Winner screen
    output logic [pong_pkg::score_w-1:0]      score_p1,
    output logic [pong_pkg::score_w-1:0]      score_p2
);

    logic up_p1_s;          // Synchronized buttons, still active low
    logic down_p1_s;
    logic up_p2_s;
    logic down_p2_s;
    logic any_press;        // Some button held
    logic ball_live;        // Ball may move
    logic paddles_live;     // Paddles may move
    logic miss_left;        // Ball out on the left, point to player 2
    logic miss_right;       // Ball out on the right, point to player 1

    button_sync u_button_sync (
        .clk_0       (clk_0),
        .rst         (rst),
        .up_p1_raw   (up_p1),
        .down_p1_raw (down_p1),
        .up_p2_raw   (up_p2),
        .down_p2_raw (down_p2),
        .up_p1       (up_p1_s),
        .down_p1     (down_p1_s),
        .up_p2       (up_p2_s),
        .down_p2     (down_p2_s),
        .any_press   (any_press)
    );

    game_state_ctrl #(
        .serve_delay (serve_delay),
        .safe_start  (safe_start)
    ) u_game_state_ctrl (
        .clk_0        (clk_0),
        .rst          (rst),
        .any_press    (any_press),
        .miss_left    (miss_left),
        .miss_right   (miss_right),
        .ball_live    (ball_live),
        .paddles_live (paddles_live),
        .ball_shown   (ball_shown),
        .game_startup (game_startup),
        .game_over    (game_over),
        .score_p1     (score_p1),
        .score_p2     (score_p2)
    );

    // Left paddle
    paddle_mover #(
        .paddle_period (paddle_period)
    ) u_paddle_p1 (
        .clk_0        (clk_0),
        .rst          (rst),
        .up           (up_p1_s),
        .down         (down_p1_s),
        .paddles_live (paddles_live),
        .pdl_y        (pdl1_y)
    );

    // Right paddle
    paddle_mover #(
        .paddle_period (paddle_period)
    ) u_paddle_p2 (
        .clk_0        (clk_0),
        .rst          (rst),
        .up           (up_p2_s),
        .down         (down_p2_s),
        .paddles_live (paddles_live),
        .pdl_y        (pdl2_y)
    );

    ball_mover #(
        .ball_period (ball_period)
    ) u_ball_mover (
        .clk_0      (clk_0),
        .rst        (rst),
        .ball_live  (ball_live),
        .pdl1_y     (pdl1_y),
        .pdl2_y     (pdl2_y),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .miss_left  (miss_left),
        .miss_right (miss_right)
    );

endmodule

`default_nettype wire

// File: paddle/paddle_mover.sv
`timescale 1ns/10ps
`default_nettype none

module paddle_mover #(
    parameter int paddle_period = pong_pkg::def_paddle_period   // Cycles per step
) (
    input  wire logic                         clk_0,
    input  wire logic                         rst,            // Async, active low
    input  wire logic                         up,             // Active low
    input  wire logic                         down,           // Active low
    input  wire logic                         paddles_live,   // Low holds at start
    output logic [pong_pkg::coord_w-1:0]      pdl_y           // Top edge
);

    logic [pong_pkg::count_w-1:0] rate_cnt;     // Cycles since last step
    logic                         single_btn;   // Exactly one button held
    logic                         step;         // Step due this cycle

    assign single_btn = up ^ down;
    assign step       = single_btn && (rate_cnt == paddle_period - 1);

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            rate_cnt <= '0;
            pdl_y    <= pong_pkg::pdl_start_y;
        end else if (!paddles_live) begin
            rate_cnt <= '0;
            pdl_y    <= pong_pkg::pdl_start_y;      // Parked on the startup and game over screens
        end else if (!single_btn) begin
            rate_cnt <= '0;                         // Neither or both held
        end else if (step) begin
            rate_cnt <= '0;
            if (!up) begin
                if (pdl_y != '0) begin
                    pdl_y <= pdl_y - 1'b1;          // Stop at the top line
                end
            end else if (pdl_y + pong_pkg::pdl_height < pong_pkg::v_video - 1) begin
                pdl_y <= pdl_y + 1'b1;              // Stops at 383
            end
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    a_pdl_in_screen: assert property (
        @(posedge clk_0) disable iff (!rst)
        pdl_y <= pong_pkg::v_video - 1 - pong_pkg::pdl_height
    );

endmodule

`default_nettype wire

// File: pong_top.f
common/pong_pkg.sv
logic/button_sync.sv
logic/game_state_ctrl.sv
paddle/paddle_mover.sv
ball/ball_mover.sv
logic/pong_top.sv
test/tb_pong.sv

// File: test/tb_pong.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pong;

    // 22 points at up to 640 steps of 2 cycles plus the serve pause and rounded up
    localparam int cycle_limit = 30_000;

    logic       clk_0 = 1'b0;
    logic       rst;                                // Active low
    logic       up_p1, down_p1, up_p2, down_p2;     // Raw active-low buttons
    logic [9:0] ball_x, ball_y, pdl1_y, pdl2_y;
    logic       ball_shown, game_startup, game_over;
    logic [3:0] score_p1, score_p2;

    int    cycle_cnt    = 0;
    int    err_cnt      = 0;
    int    err_mark     = 0;                        // Errors before the running test
    int    tests_passed = 0;
    int    tests_failed = 0;
    string waiting_for  = "reset";                  // Named in the timeout line

    pong_top #(.ball_period(2), .paddle_period(2), .serve_delay(8), .safe_start(4)) DUT (.*);

    always #10 clk_0 = ~clk_0;                      // 20 ns period

    always @(posedge clk_0) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("Timeout after %0d cycles while waiting for %s", cycle_limit, waiting_for);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        $display("MISMATCH at %0d ns: %s", $time, msg);
        err_cnt++;
    endtask

    // Pin order is {down_p2, up_p2, down_p1, up_p1} and a 0 is a press
    task automatic hold_buttons(input logic [3:0] pins, input int cycles);
        {down_p2, up_p2, down_p1, up_p1} = pins;
        repeat (cycles) @(negedge clk_0);
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d mismatches)", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // At most one step toward the single held button and never beyond 0 or 383
    function automatic bit paddle_ok(input logic up, input logic down,
                                     input logic [9:0] prev, input logic [9:0] cur);
        if (!up && down) begin
            return (cur == prev) || (prev != 0 && cur == prev - 10'd1);
        end
        if (up && !down) begin
            return ((cur == prev) || (cur == prev + 10'd1)) && cur <= 383;
        end
        return cur == prev;                         // Both or neither held
    endfunction

    // One point for the player opposite the edge or a clear of both at game over
    function automatic bit score_ok(input logic [3:0] prev1, input logic [3:0] prev2,
                                    input logic [3:0] cur1, input logic [3:0] cur2,
                                    input logic [9:0] x, input logic over_rose);
        if (cur1 == prev1 + 4'd1 && cur2 == prev2) begin
            return x >= 623;
        end
        if (cur2 == prev2 + 4'd1 && cur1 == prev1) begin
            return x == 0;
        end
        return cur1 == 0 && cur2 == 0 && over_rose;
    endfunction

    chk_startup: assert property (@(posedge clk_0) disable iff (!rst)
        game_startup |-> !game_over && !ball_shown && score_p1 == 0 && score_p2 == 0 &&
            ball_x == 320 && ball_y == 240 && pdl1_y == 191 && pdl2_y == 191)
        else report_error("startup screen not in its reset state");
    chk_over: assert property (@(posedge clk_0) disable iff (!rst)
        game_over |-> !ball_shown && score_p1 == 0 && score_p2 == 0)
        else report_error("game over screen shows the ball or a score");
    // Paddle sees the buttons 3 samples late
    chk_pdl1: assert property (@(posedge clk_0) disable iff (!rst)
        $past(!game_startup && !game_over) |->
            paddle_ok($past(up_p1, 3), $past(down_p1, 3), $past(pdl1_y), pdl1_y))
        else report_error("paddle 1 move does not match its buttons");
    chk_pdl2: assert property (@(posedge clk_0) disable iff (!rst)
        $past(!game_startup && !game_over) |->
            paddle_ok($past(up_p2, 3), $past(down_p2, 3), $past(pdl2_y), pdl2_y))
        else report_error("paddle 2 move does not match its buttons");
    chk_hidden: assert property (@(posedge clk_0) disable iff (!rst)
        !ball_shown && $past(!ball_shown) |-> ball_x == 320 && ball_y == 240)
        else report_error("hidden ball is not at centre");
    chk_serve_delay: assert property (@(posedge clk_0) disable iff (!rst)
        $rose(ball_shown) |-> !$past(ball_shown, 8) && ball_x == 320 && ball_y == 240)
        else report_error("ball shown before the serve pause ended or away from centre");
    chk_first_move: assert property (@(posedge clk_0) disable iff (!rst)
        $past(ball_shown) && $past(ball_x) == 320 && $past(ball_y) == 240 &&
            (ball_x != 320 || ball_y != 240) |-> ball_x == 319 && ball_y == 239)
        else report_error("first ball move from centre is not to (319, 239)");
    chk_ball_box: assert property (@(posedge clk_0) disable iff (!rst)
        ball_shown |-> ball_x <= 623 && ball_y <= 463)
        else report_error("ball outside the playfield");
    chk_top_bounce: assert property (@(posedge clk_0) disable iff (!rst)
        $past(ball_shown) && $past(ball_y) == 0 && ball_y != 0 |-> ball_y == 1)
        else report_error("ball did not bounce down off the top wall");
    chk_score: assert property (@(posedge clk_0) disable iff (!rst)
        (score_p1 != $past(score_p1) || score_p2 != $past(score_p2)) |->
            score_ok($past(score_p1), $past(score_p2), score_p1, score_p2,
                     $past(ball_x), $rose(game_over)))
        else report_error("score change is not one point or a game over clear");
    chk_win: assert property (@(posedge clk_0) disable iff (!rst)
        $rose(game_over) |-> $past(score_p1) == 10 || $past(score_p2) == 10)
        else report_error("game over without a score of 10");

    initial begin
        int unsigned seed_val;
        seed_val = $urandom(32'h8800);              // Seeds the generator
        rst = 1'b0;
        hold_buttons(4'hf, 4);                      // All released during reset
        rst = 1'b1;

        hold_buttons(4'he, 1);                      // Short press inside the safety wait
        hold_buttons(4'hf, 20);
        assert (game_startup && !game_over)
            else report_error("startup screen left during the safety wait");
        end_test("reset and startup");

        hold_buttons(4'hd, $urandom_range(2, 6));   // Player 1 down leaves startup
        hold_buttons(4'hf, 0);
        waiting_for = "the serve";
        while (game_startup) @(negedge clk_0);
        waiting_for = "the ball to appear";
        while (!ball_shown) @(negedge clk_0);
        waiting_for = "the first ball move";
        while (ball_x == 320 && ball_y == 240) @(negedge clk_0);
        end_test("serve");

        hold_buttons(4'h6, $urandom_range(20, 80)); // P1 up and P2 down
        hold_buttons(4'hc, $urandom_range(20, 80)); // P1 both and P2 none
        hold_buttons(4'h3, $urandom_range(20, 80)); // P1 none and P2 both
        hold_buttons(4'h5, 0);                      // Both down to the stop
        waiting_for = "both paddles at the bottom";
        while (pdl1_y != 383 || pdl2_y != 383) @(negedge clk_0);
        hold_buttons(4'h5, $urandom_range(10, 30));
        hold_buttons(4'ha, 0);                      // Both up and parked at the top
        waiting_for = "both paddles at the top";
        while (pdl1_y != 0 || pdl2_y != 0) @(negedge clk_0);
        hold_buttons(4'ha, $urandom_range(10, 30));
        hold_buttons(4'hf, 1);
        end_test("paddles");

        waiting_for = "the ball at the top wall";
        while (!(ball_shown && ball_y == 0)) @(negedge clk_0);
        waiting_for = "the ball at a side edge";
        while (!(ball_shown && (ball_x == 0 || ball_x >= 623))) @(negedge clk_0);
        end_test("ball bounds and bounces");

        waiting_for = "game over";
        while (!game_over) @(negedge clk_0);
        hold_buttons(4'hb, $urandom_range(2, 6));   // Player 2 up restarts
        hold_buttons(4'hf, 0);
        waiting_for = "the restart";
        while (game_over) @(negedge clk_0);
        waiting_for = "the ball after the restart";
        while (!ball_shown) @(negedge clk_0);
        end_test("scoring and game over");

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
